// ==== axi_rab_cfg.f ====
+incdir+common
common/rab_cfg_pkg.sv
miss_handler/mh_fifo.sv
miss_handler/miss_handler.sv
rtl/axi_lite_slave.sv
rtl/l1_cfg_regs.sv
rtl/axi_rab_cfg.sv
dv/tb_axi_rab_cfg.sv

// ==== Makefile ====
# Verilator build and run of the RAB config testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f axi_rab_cfg.f --top-module tb_axi_rab_cfg
	./obj_dir/Vtb_axi_rab_cfg

clean:
	rm -rf obj_dir

// ==== dv/tb_axi_rab_cfg.sv ====
// Table-driven testbench for the RAB config block that the Makefile in the project root runs
`include "rab_cfg_macros.svh"

module tb_axi_rab_cfg
  import rab_cfg_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  typedef enum logic [1:0] {OP_WR, OP_RD, OP_MISS, OP_RD_STALL} op_e;

  // Stimulus row whose exp field the model fills in before the run
  typedef struct packed
  {
    op_e      op;
    reg_idx_t idx;
    data_t    data;   // Miss rows carry meta in [41:32] and address in [31:0]
    strb_t    strb;
    data_t    exp;
  } row_t;

  localparam data_t ADDR_MASK  = data_t'({`RAB_VIRT_WIDTH{1'b1}});
  localparam data_t META_MASK  = data_t'({`RAB_META_WIDTH{1'b1}});
  localparam data_t META_EMPTY = data_t'(64'h8000_0000);   // Empty flag in bit 31

  logic Clk_CI, Rst_RBI;
  logic s_axi_awvalid_i, s_axi_awready_o, s_axi_wvalid_i, s_axi_wready_o;
  logic s_axi_bvalid_o, s_axi_bready_i, s_axi_arvalid_i, s_axi_arready_o;
  logic s_axi_rvalid_o, s_axi_rready_i, Miss_i, mh_fifo_full_o;
  logic [1:0] s_axi_bresp_o, s_axi_rresp_o;
  addr_t s_axi_awaddr_i, s_axi_araddr_i;
  data_t s_axi_wdata_i, s_axi_rdata_o;
  strb_t s_axi_wstrb_i;
  data_t [`RAB_N_REGS-1:0] L1Cfg_o;
  virt_addr_t MissAddr_i;
  miss_meta_t MissMeta_i;

  row_t        rows [$];
  logic [31:0] rng_state = 32'hb9be;
  int unsigned cycle_cnt;
  int unsigned cycle_limit;

  axi_rab_cfg uut (.*);

  initial
  begin
    Clk_CI = 1'b0;
    forever #20 Clk_CI = ~Clk_CI;
  end

  always @(posedge Clk_CI)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == cycle_limit)
    begin
      $display("Errors found");
      $fatal(1, "Timeout after %0d cycles, the DUT stopped answering", cycle_cnt);
    end
  end

  task automatic check_value(input string name, input data_t got, input data_t exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("Errors found");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic data_t rand64();
    logic [31:0] hi;
    rng_state = xorshift32(rng_state);
    hi = rng_state;
    rng_state = xorshift32(rng_state);
    return {hi, rng_state};
  endfunction

  // Visible bits of a virtual, physical or flags register
  function automatic data_t width_mask(input reg_idx_t idx);
    if (!idx[1])
      return ADDR_MASK;
    else if (!idx[0])
      return data_t'({`RAB_PHYS_WIDTH{1'b1}});
    return data_t'({`RAB_N_FLAGS{1'b1}});
  endfunction

  function automatic data_t byte_mask(input strb_t strb);
    data_t m;
    for (int b = 0; b < $bits(strb_t); b++)
      m[8*b +: 8] = {8{strb[b]}};
    return m;
  endfunction

  task automatic add_row(input op_e op, input reg_idx_t idx, input data_t data, input strb_t strb);
    rows.push_back('{op, idx, data, strb, '0});
  endtask

  task automatic add_misses(input int n);
    repeat (n) add_row(OP_MISS, '0, rand64() & 64'h3ff_ffff_ffff, '0);
  endtask

  task automatic read_rows(input reg_idx_t idx, input int n);
    repeat (n) add_row(OP_RD, idx, '0, '0);
  endtask

  task automatic build_table();
    data_t d;
    add_row(OP_WR, 4, 64'hffee_ddcc_bbaa_9988, 8'hff);
    add_row(OP_WR, 6, 64'hffee_ddcc_bbaa_9988, 8'hff);
    add_row(OP_WR, 7, 64'hffee_ddcc_bbaa_9988, 8'hff);
    read_rows(4, 1);
    read_rows(6, 1);
    read_rows(7, 1);
    add_row(OP_WR, 6, 64'h1122_3344_5566_7788, 8'hf2);   // Bytes 5 to 7 beyond 40 bits
    read_rows(6, 1);
    add_row(OP_WR, 5, 64'h1122_3344_5566_7788, 8'h3c);
    read_rows(5, 1);
    for (int i = 8; i < 16; i++)
    begin
      d = rand64();
      add_row(OP_WR, reg_idx_t'(i), d, (i < 12) ? 8'hff : d[15:8]);
      read_rows(reg_idx_t'(i), 1);
    end
    add_misses(3);
    read_rows(0, 3);
    read_rows(1, 4);   // Last one finds the meta queue empty
    add_misses(2);
    add_row(OP_WR, 0, 64'hdead_beef_cafe_f00d, 8'hff);
    add_row(OP_WR, 1, 64'h0000_0000_0000_0155, 8'hff);
    read_rows(0, 3);
    read_rows(1, 3);
    add_misses(`RAB_MH_DEPTH + 1);
    read_rows(0, `RAB_MH_DEPTH);
    read_rows(1, `RAB_MH_DEPTH + 1);
    add_misses(3);
    add_row(OP_RD_STALL, 0, '0, '0);
    read_rows(0, 2);
    read_rows(1, 3);
  endtask

  // Reference model of registers and miss queues
  task automatic predict();
    data_t    regs [`RAB_N_REGS];
    data_t    addr_q [$];
    data_t    meta_q [$];
    data_t    m;
    reg_idx_t idx;
    foreach (regs[k])
      regs[k] = '0;
    foreach (rows[i])
    begin
      idx = rows[i].idx;
      case (rows[i].op)
        OP_WR:
        begin
          m = byte_mask(rows[i].strb);
          regs[idx] = (regs[idx] & ~m) | (rows[i].data & m);
          rows[i].exp = regs[idx] & width_mask(idx);
          if (idx == 0 && addr_q.size() < `RAB_MH_DEPTH)
            addr_q.push_back(rows[i].data & ADDR_MASK);
          if (idx == 1 && meta_q.size() < `RAB_MH_DEPTH)
            meta_q.push_back(rows[i].data & META_MASK);
        end
        OP_MISS:
        begin
          rows[i].exp = data_t'(addr_q.size() == `RAB_MH_DEPTH || meta_q.size() == `RAB_MH_DEPTH);
          if (addr_q.size() < `RAB_MH_DEPTH)
            addr_q.push_back(rows[i].data & ADDR_MASK);
          if (meta_q.size() < `RAB_MH_DEPTH)
            meta_q.push_back((rows[i].data >> `RAB_VIRT_WIDTH) & META_MASK);
        end
        default:
        begin
          if (idx == 0)
            rows[i].exp = (addr_q.size() > 0) ? addr_q.pop_front() : '0;
          else if (idx == 1)
            rows[i].exp = (meta_q.size() > 0) ? meta_q.pop_front() : META_EMPTY;
          else
            rows[i].exp = regs[idx] & width_mask(idx);
        end
      endcase
    end
  endtask

  task automatic bus_write(input reg_idx_t idx, input data_t data, input strb_t strb);
    logic aw_acc, w_acc, b_acc;
    s_axi_awaddr_i  = addr_t'(idx) << `RAB_ADDR_LSB;
    s_axi_awvalid_i = 1'b1;
    s_axi_wdata_i   = data;
    s_axi_wstrb_i   = strb;
    s_axi_wvalid_i  = 1'b1;
    s_axi_bready_i  = 1'b1;
    b_acc = 1'b0;
    while (!b_acc)
    begin
      @(negedge Clk_CI);   // Handshake seen here completes on the next rising edge
      aw_acc = s_axi_awvalid_i & s_axi_awready_o;
      w_acc  = s_axi_wvalid_i & s_axi_wready_o;
      b_acc  = s_axi_bvalid_o & s_axi_bready_i;
      if (b_acc)
      begin
        check_value("s_axi_bresp_o", data_t'(s_axi_bresp_o), '0);
        check_value("s_axi_awready_o", data_t'(s_axi_awready_o), '0);
        check_value("s_axi_wready_o", data_t'(s_axi_wready_o), '0);
      end
      @(posedge Clk_CI);
      #2;
      if (aw_acc)
        s_axi_awvalid_i = 1'b0;
      if (w_acc)
        s_axi_wvalid_i = 1'b0;
    end
    check_value("s_axi_awready_o", data_t'(s_axi_awready_o), data_t'(1));
    check_value("s_axi_wready_o", data_t'(s_axi_wready_o), data_t'(1));
  endtask

  task automatic bus_read(input reg_idx_t idx, input int stall, output data_t data);
    logic ar_acc, seen, done;
    int   held;
    s_axi_araddr_i  = addr_t'(idx) << `RAB_ADDR_LSB;
    s_axi_arvalid_i = 1'b1;
    s_axi_rready_i  = (stall == 0);
    seen = 1'b0;
    done = 1'b0;
    held = 0;
    data = '0;
    while (!done)
    begin
      @(negedge Clk_CI);
      ar_acc = s_axi_arvalid_i & s_axi_arready_o;
      if (s_axi_rvalid_o)
      begin
        check_value("s_axi_arready_o", data_t'(s_axi_arready_o), '0);
        if (seen)
          check_value("s_axi_rdata_o (stalled)", s_axi_rdata_o, data);
        data = s_axi_rdata_o;
        seen = 1'b1;
        done = s_axi_rready_i;
        if (!s_axi_rready_i)
          held++;
        else
          check_value("s_axi_rresp_o", data_t'(s_axi_rresp_o), '0);
      end
      @(posedge Clk_CI);
      #2;
      if (ar_acc)
        s_axi_arvalid_i = 1'b0;
      if (held == stall)
        s_axi_rready_i = 1'b1;   // Stall over
    end
    s_axi_rready_i = 1'b0;
    check_value("s_axi_arready_o", data_t'(s_axi_arready_o), data_t'(1));
  endtask

  task automatic drive_miss(input data_t data, input data_t exp_full);
    Miss_i     = 1'b1;
    MissAddr_i = data[`RAB_VIRT_WIDTH-1:0];
    MissMeta_i = data[`RAB_VIRT_WIDTH +: `RAB_META_WIDTH];
    @(negedge Clk_CI);
    check_value("mh_fifo_full_o", data_t'(mh_fifo_full_o), exp_full);
    @(posedge Clk_CI);
    #2;
    Miss_i = 1'b0;
  endtask

  initial
  begin
    data_t got;
    Rst_RBI         = 1'b0;
    cycle_cnt       = 0;
    s_axi_awaddr_i  = '0;
    s_axi_awvalid_i = 1'b0;
    s_axi_wdata_i   = '0;
    s_axi_wstrb_i   = '0;
    s_axi_wvalid_i  = 1'b0;
    s_axi_bready_i  = 1'b0;
    s_axi_araddr_i  = '0;
    s_axi_arvalid_i = 1'b0;
    s_axi_rready_i  = 1'b0;
    Miss_i          = 1'b0;
    MissAddr_i      = '0;
    MissMeta_i      = '0;
    build_table();
    predict();
    cycle_limit = 40 * rows.size() + 8;
    repeat (4) @(posedge Clk_CI);
    #2;
    Rst_RBI = 1'b1;
    check_value("s_axi_bvalid_o", data_t'(s_axi_bvalid_o), '0);
    check_value("s_axi_rvalid_o", data_t'(s_axi_rvalid_o), '0);
    check_value("mh_fifo_full_o", data_t'(mh_fifo_full_o), '0);
    check_value("s_axi_awready_o", data_t'(s_axi_awready_o), data_t'(1));
    check_value("s_axi_wready_o", data_t'(s_axi_wready_o), data_t'(1));
    check_value("s_axi_arready_o", data_t'(s_axi_arready_o), data_t'(1));
    foreach (rows[i])
    begin
      case (rows[i].op)
        OP_WR:
        begin
          bus_write(rows[i].idx, rows[i].data, rows[i].strb);
          check_value($sformatf("L1Cfg_o[%0d]", rows[i].idx), L1Cfg_o[rows[i].idx], rows[i].exp);
        end
        OP_MISS:
          drive_miss(rows[i].data, rows[i].exp);
        default:
        begin
          bus_read(rows[i].idx, (rows[i].op == OP_RD_STALL) ? 3 : 0, got);
          check_value($sformatf("s_axi_rdata_o idx %0d", rows[i].idx), got, rows[i].exp);
        end
      endcase
    end
    $display("No errors");
    $finish;
  end

endmodule

// ==== rtl/axi_rab_cfg.sv ====
// Top level of the RAB config block that joins bus slave, L1 register file and miss handler
`include "rab_cfg_macros.svh"

module axi_rab_cfg
  import rab_cfg_pkg::*;
(
  input  logic                    Clk_CI,
  input  logic                    Rst_RBI,
  input  addr_t                   s_axi_awaddr_i,
  input  logic                    s_axi_awvalid_i,
  output logic                    s_axi_awready_o,
  input  data_t                   s_axi_wdata_i,
  input  strb_t                   s_axi_wstrb_i,
  input  logic                    s_axi_wvalid_i,
  output logic                    s_axi_wready_o,
  output logic [1:0]              s_axi_bresp_o,
  output logic                    s_axi_bvalid_o,
  input  logic                    s_axi_bready_i,
  input  addr_t                   s_axi_araddr_i,
  input  logic                    s_axi_arvalid_i,
  output logic                    s_axi_arready_o,
  output data_t                   s_axi_rdata_o,
  output logic [1:0]              s_axi_rresp_o,
  output logic                    s_axi_rvalid_o,
  input  logic                    s_axi_rready_i,
  output data_t [`RAB_N_REGS-1:0] L1Cfg_o,
  input  logic                    Miss_i,
  input  virt_addr_t              MissAddr_i,
  input  miss_meta_t              MissMeta_i,
  output logic                    mh_fifo_full_o
);

  logic     wr_en, rd_done, rd_sel_mh;
  reg_idx_t wr_idx, rd_idx;
  data_t    wr_data, rd_data_cfg, rd_data_mh;
  strb_t    wr_strb;

  axi_lite_slave i_slave (
    .Clk_CI, .Rst_RBI,
    .s_axi_awaddr_i, .s_axi_awvalid_i, .s_axi_awready_o,
    .s_axi_wdata_i, .s_axi_wstrb_i, .s_axi_wvalid_i, .s_axi_wready_o,
    .s_axi_bresp_o, .s_axi_bvalid_o, .s_axi_bready_i,
    .s_axi_araddr_i, .s_axi_arvalid_i, .s_axi_arready_o,
    .s_axi_rdata_o, .s_axi_rresp_o, .s_axi_rvalid_o, .s_axi_rready_i,
    .rd_data_cfg_i (rd_data_cfg),
    .rd_data_mh_i  (rd_data_mh),
    .rd_sel_mh_i   (rd_sel_mh),
    .wr_en_o       (wr_en),
    .wr_idx_o      (wr_idx),
    .wr_data_o     (wr_data),
    .wr_strb_o     (wr_strb),
    .rd_idx_o      (rd_idx),
    .rd_done_o     (rd_done)
  );

  l1_cfg_regs i_regs (
    .Clk_CI, .Rst_RBI,
    .wr_en_i (wr_en), .wr_idx_i (wr_idx), .wr_data_i (wr_data), .wr_strb_i (wr_strb),
    .rd_idx_i (rd_idx), .rd_data_o (rd_data_cfg), .L1Cfg_o
  );

  miss_handler i_mh (
    .Clk_CI, .Rst_RBI, .Miss_i, .MissAddr_i, .MissMeta_i,
    .wr_en_i (wr_en), .wr_idx_i (wr_idx), .wr_data_i (wr_data),
    .rd_idx_i (rd_idx), .rd_done_i (rd_done),
    .rd_data_o (rd_data_mh), .rd_sel_mh_o (rd_sel_mh), .mh_fifo_full_o
  );

endmodule

// ==== rtl/l1_cfg_regs.sv ====
// L1 slice configuration register file with byte strobes and role masking behind the bus slave
`include "rab_cfg_macros.svh"

module l1_cfg_regs
  import rab_cfg_pkg::*;
(
  input  logic                      Clk_CI,
  input  logic                      Rst_RBI,
  input  logic                      wr_en_i,
  input  reg_idx_t                  wr_idx_i,
  input  data_t                     wr_data_i,
  input  strb_t                     wr_strb_i,
  input  reg_idx_t                  rd_idx_i,
  output data_t                     rd_data_o,
  output data_t [`RAB_N_REGS-1:0]   L1Cfg_o
);

  localparam int unsigned N_BYTES = `RAB_DATA_WIDTH / 8;

  data_t [`RAB_N_REGS-1:0] regs_q;
  int unsigned             wr_bytes;

  // Register role follows from the low index bits
  function automatic reg_role_e role_of(reg_idx_t idx);
    if (!idx[1])
      return ROLE_VIRT;
    else if (!idx[0])
      return ROLE_PHYS;
    else
      return ROLE_FLAGS;
  endfunction

  function automatic int unsigned role_bytes(reg_role_e role);
    case (role)
      ROLE_VIRT:  return (`RAB_VIRT_WIDTH + 7) / 8;
      ROLE_PHYS:  return (`RAB_PHYS_WIDTH + 7) / 8;
      default:    return (`RAB_N_FLAGS + 7) / 8;
    endcase
  endfunction

  function automatic data_t role_mask(reg_role_e role);
    case (role)
      ROLE_VIRT:  return data_t'({`RAB_VIRT_WIDTH{1'b1}});
      ROLE_PHYS:  return data_t'({`RAB_PHYS_WIDTH{1'b1}});
      default:    return data_t'({`RAB_N_FLAGS{1'b1}});
    endcase
  endfunction

  assign wr_bytes = role_bytes(role_of(wr_idx_i));

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
      regs_q <= '0;
    else if (wr_en_i)
    begin
      for (int b = 0; b < N_BYTES; b++)
      begin
        if (b >= wr_bytes)
          regs_q[wr_idx_i][8*b +: 8] <= 8'h00;   // Outside role width
        else if (wr_strb_i[b])
          regs_q[wr_idx_i][8*b +: 8] <= wr_data_i[8*b +: 8];
      end
    end
  end

  always_comb
  begin
    for (int j = 0; j < `RAB_N_REGS; j++)
      L1Cfg_o[j] = regs_q[j] & role_mask(role_of(reg_idx_t'(j)));
  end

  assign rd_data_o = L1Cfg_o[rd_idx_i];

endmodule

// ==== rtl/axi_lite_slave.sv ====
// AXI4-Lite slave channel logic that turns bus transfers into register write and read strobes
`include "rab_cfg_macros.svh"

module axi_lite_slave
  import rab_cfg_pkg::*;
(
  input  logic       Clk_CI,
  input  logic       Rst_RBI,

  input  addr_t      s_axi_awaddr_i,
  input  logic       s_axi_awvalid_i,
  output logic       s_axi_awready_o,
  input  data_t      s_axi_wdata_i,
  input  strb_t      s_axi_wstrb_i,
  input  logic       s_axi_wvalid_i,
  output logic       s_axi_wready_o,
  output logic [1:0] s_axi_bresp_o,
  output logic       s_axi_bvalid_o,
  input  logic       s_axi_bready_i,
  input  addr_t      s_axi_araddr_i,
  input  logic       s_axi_arvalid_i,
  output logic       s_axi_arready_o,
  output data_t      s_axi_rdata_o,
  output logic [1:0] s_axi_rresp_o,
  output logic       s_axi_rvalid_o,
  input  logic       s_axi_rready_i,

  input  data_t      rd_data_cfg_i,
  input  data_t      rd_data_mh_i,
  input  logic       rd_sel_mh_i,

  output logic       wr_en_o,
  output reg_idx_t   wr_idx_o,
  output data_t      wr_data_o,
  output strb_t      wr_strb_o,
  output reg_idx_t   rd_idx_o,
  output logic       rd_done_o
);

  logic     aw_done_q;
  logic     w_done_q;
  logic     wr_seen_q;   // wr_en already issued for the current write
  logic     ar_done_q;
  logic     aw_hs;
  logic     w_hs;
  logic     b_hs;
  logic     ar_hs;
  reg_idx_t aw_idx_q;
  reg_idx_t ar_idx_q;
  reg_idx_t ar_idx_in;
  data_t    wdata_q;
  strb_t    wstrb_q;
  data_t    rdata_q;

  assign s_axi_awready_o = ~aw_done_q;
  assign s_axi_wready_o  = ~w_done_q;
  assign s_axi_arready_o = ~ar_done_q;

  assign aw_hs = s_axi_awvalid_i & s_axi_awready_o;
  assign w_hs  = s_axi_wvalid_i & s_axi_wready_o;
  assign ar_hs = s_axi_arvalid_i & s_axi_arready_o;

  // Response is pending as soon as both write halves are in
  assign s_axi_bvalid_o = aw_done_q & w_done_q;
  assign s_axi_bresp_o  = 2'b00;
  assign b_hs           = s_axi_bvalid_o & s_axi_bready_i;

  assign wr_en_o   = s_axi_bvalid_o & ~wr_seen_q;
  assign wr_idx_o  = aw_idx_q;
  assign wr_data_o = wdata_q;
  assign wr_strb_o = wstrb_q;

  assign s_axi_rvalid_o = ar_done_q;
  assign s_axi_rresp_o  = 2'b00;
  assign s_axi_rdata_o  = rdata_q;
  assign rd_done_o      = ar_done_q & s_axi_rready_i;

  assign ar_idx_in = reg_idx_t'(s_axi_araddr_i[`RAB_ADDR_LSB +: $bits(reg_idx_t)]);

  // Held index drives the pop and incoming index drives the data capture
  assign rd_idx_o = ar_done_q ? ar_idx_q : ar_idx_in;

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
      wr_seen_q <= 1'b0;
    end
    else if (b_hs)
    begin
      aw_done_q <= 1'b0;   // Ready returns in the next cycle
      w_done_q  <= 1'b0;
      wr_seen_q <= 1'b0;
    end
    else
    begin
      if (aw_hs)
        aw_done_q <= 1'b1;
      if (w_hs)
        w_done_q <= 1'b1;
      if (wr_en_o)
        wr_seen_q <= 1'b1;
    end
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
      ar_done_q <= 1'b0;
    else if (rd_done_o)
      ar_done_q <= 1'b0;
    else if (ar_hs)
      ar_done_q <= 1'b1;
  end

  always_ff @(posedge Clk_CI)
  begin
    if (aw_hs)
      aw_idx_q <= reg_idx_t'(s_axi_awaddr_i[`RAB_ADDR_LSB +: $bits(reg_idx_t)]);
    if (w_hs)
    begin
      wdata_q <= s_axi_wdata_i;
      wstrb_q <= s_axi_wstrb_i;
    end
    if (ar_hs)
    begin
      ar_idx_q <= ar_idx_in;
      rdata_q  <= rd_sel_mh_i ? rd_data_mh_i : rd_data_cfg_i;  // Frozen for the whole R phase
    end
  end

  assert property (@(posedge Clk_CI) disable iff (!Rst_RBI) wr_en_o |=> !wr_en_o)
    else $error("wr_en high for more than one cycle");

  // A stalled read keeps both valid and data
  assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    s_axi_rvalid_o && !s_axi_rready_i |=> s_axi_rvalid_o && $stable(s_axi_rdata_o))
    else $error("rvalid or rdata changed before rready");

endmodule

// ==== miss_handler/miss_handler.sv ====
// Miss queue of address and metadata FIFOs that misses or bus writes fill and the bus pops
`include "rab_cfg_macros.svh"

module miss_handler
  import rab_cfg_pkg::*;
(
  input  logic       Clk_CI,
  input  logic       Rst_RBI,
  input  logic       Miss_i,
  input  virt_addr_t MissAddr_i,
  input  miss_meta_t MissMeta_i,
  input  logic       wr_en_i,
  input  reg_idx_t   wr_idx_i,
  input  data_t      wr_data_i,
  input  reg_idx_t   rd_idx_i,
  input  logic       rd_done_i,
  output data_t      rd_data_o,
  output logic       rd_sel_mh_o,
  output logic       mh_fifo_full_o
);

  localparam reg_idx_t MH_ADDR_IDX  = reg_idx_t'(0);
  localparam reg_idx_t MH_META_IDX  = reg_idx_t'(1);
  localparam int       META_EMPTY_B = 31;   // Empty flag position in the meta word

  logic       addr_push, addr_pop, addr_empty, addr_full;
  logic       meta_push, meta_pop, meta_empty, meta_full;
  virt_addr_t addr_din, addr_head;
  miss_meta_t meta_din, meta_head;

  // Miss input has priority and a colliding bus push is lost
  always_comb
  begin
    addr_push = Miss_i | (wr_en_i && wr_idx_i == MH_ADDR_IDX);
    meta_push = Miss_i | (wr_en_i && wr_idx_i == MH_META_IDX);
    addr_din  = Miss_i ? MissAddr_i : wr_data_i[`RAB_VIRT_WIDTH-1:0];
    meta_din  = Miss_i ? MissMeta_i : wr_data_i[`RAB_META_WIDTH-1:0];
  end

  assign mh_fifo_full_o = (addr_push & addr_full) | (meta_push & meta_full);

  assign rd_sel_mh_o = (rd_idx_i == MH_ADDR_IDX) || (rd_idx_i == MH_META_IDX);
  assign addr_pop    = rd_done_i && rd_idx_i == MH_ADDR_IDX;
  assign meta_pop    = rd_done_i && rd_idx_i == MH_META_IDX;

  always_comb
  begin
    rd_data_o = '0;
    if (rd_idx_i == MH_ADDR_IDX)
      rd_data_o[`RAB_VIRT_WIDTH-1:0] = addr_empty ? '0 : addr_head;
    else if (rd_idx_i == MH_META_IDX)
    begin
      rd_data_o[META_EMPTY_B]          = meta_empty;
      rd_data_o[`RAB_META_WIDTH-1:0]   = meta_empty ? '0 : meta_head;
    end
  end

  mh_fifo #(.payload_t(virt_addr_t), .DEPTH(`RAB_MH_DEPTH)) i_addr_fifo (
    .Clk_CI  (Clk_CI),
    .Rst_RBI (Rst_RBI),
    .push_i  (addr_push),
    .data_i  (addr_din),
    .pop_i   (addr_pop),
    .data_o  (addr_head),
    .empty_o (addr_empty),
    .full_o  (addr_full)
  );

  mh_fifo #(.payload_t(miss_meta_t), .DEPTH(`RAB_MH_DEPTH)) i_meta_fifo (
    .Clk_CI  (Clk_CI),
    .Rst_RBI (Rst_RBI),
    .push_i  (meta_push),
    .data_i  (meta_din),
    .pop_i   (meta_pop),
    .data_o  (meta_head),
    .empty_o (meta_empty),
    .full_o  (meta_full)
  );

endmodule

// ==== miss_handler/mh_fifo.sv ====
// Small synchronous FIFO for miss entries whose payload type the miss handler sets per instance
module mh_fifo #(
  parameter type         payload_t = logic [7:0],
  parameter int unsigned DEPTH     = 4
) (
  input  logic     Clk_CI,
  input  logic     Rst_RBI,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     empty_o,
  output logic     full_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  payload_t                   mem_q [DEPTH];
  logic [PTR_W-1:0]           wr_ptr_q;
  logic [PTR_W-1:0]           rd_ptr_q;
  logic [$clog2(DEPTH+1)-1:0] count_q;
  logic                       do_push;
  logic                       do_pop;

  assign empty_o = (count_q == 0);
  assign full_o  = (count_q == DEPTH);
  assign do_push = push_i & ~full_o;    // Dropped when full
  assign do_pop  = pop_i & ~empty_o;
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (do_pop)
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      if (do_push && !do_pop)
        count_q <= count_q + 1'b1;
      else if (do_pop && !do_push)
        count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge Clk_CI)
  begin
    if (do_push)
      mem_q[wr_ptr_q] <= data_i;
  end

  assert property (@(posedge Clk_CI) disable iff (!Rst_RBI) count_q <= DEPTH)
    else $error("FIFO count beyond depth");

  assert property (@(posedge Clk_CI) disable iff (!Rst_RBI) pop_i && empty_o |=> $stable(rd_ptr_q))
    else $error("Pop on empty FIFO moved the read pointer");

endmodule

// ==== common/rab_cfg_pkg.sv ====
// Shared data, address and register-role types that the RTL of the RAB config block imports
`include "rab_cfg_macros.svh"

package rab_cfg_pkg;

  typedef logic [`RAB_DATA_WIDTH-1:0] data_t;
  typedef logic [`RAB_DATA_WIDTH/8-1:0] strb_t;
  typedef logic [`RAB_ADDR_WIDTH-1:0] addr_t;

  // Word index into the L1 register file
  typedef logic [$clog2(`RAB_N_REGS)-1:0] reg_idx_t;

  typedef logic [`RAB_VIRT_WIDTH-1:0] virt_addr_t;
  typedef logic [`RAB_META_WIDTH-1:0] miss_meta_t;

  // Role of a slice register sets its width
  typedef enum logic [1:0]
  {
    ROLE_VIRT  = 2'd0,
    ROLE_PHYS  = 2'd1,
    ROLE_FLAGS = 2'd2
  } reg_role_e;

endpackage

// ==== common/rab_cfg_macros.svh ====
// Widths, depths and register address layout of the RAB config block for RTL and testbench
`ifndef RAB_CFG_MACROS_SVH
`define RAB_CFG_MACROS_SVH

// Bus and register file
`define RAB_DATA_WIDTH 64
`define RAB_ADDR_WIDTH 32
`define RAB_N_REGS     16   // Four slices of four registers
`define RAB_ADDR_LSB   3    // Byte offset within a 64-bit word

// Slice register roles
`define RAB_VIRT_WIDTH 32
`define RAB_PHYS_WIDTH 40
`define RAB_N_FLAGS    4

// Miss handling
`define RAB_META_WIDTH 10
`define RAB_MH_DEPTH   4

`endif
